// ==== list.f ====
hdl/soc_pkg.sv
hdl/reset_seq.sv
hdl/bus_router.sv
hdl/dev_table.sv
hdl/gpio.sv
hdl/int_ctrl.sv
hdl/soc_top.sv
sim/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the SoC testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_soc -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_soc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// ==== sim/tb_soc.sv ====
// ########################################################################
// soc testbench
// drives the peripheral bus of the SoC top level and checks bus timing,
// device table, gpio, interrupts, warm reset and power-off
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_soc;
	import soc_pkg::*;

	localparam int GPIOA_COUNT = 8;
	localparam int GPIOB_COUNT = 4;
	localparam int RST_CYCLES  = 16;
	localparam logic [31:0] SEED = 32'hfff77f31;
	// limit well above the roughly 700 cycles the tests take
	localparam int MAX_CYCLES = 4000;
	localparam int NO_RDY_WAIT = 50;

	// word addresses of the slaves back to back from zero
	localparam int A_DEVTBL = 0;
	localparam int A_GPIOA  = int'(SLV_MAPSZ[SLV_DEVTBL]) / SEL_W;
	localparam int A_GPIOB  = A_GPIOA + int'(SLV_MAPSZ[SLV_GPIOA]) / SEL_W;
	localparam int A_INTC   = A_GPIOB + int'(SLV_MAPSZ[SLV_GPIOB]) / SEL_W;
	localparam int A_INV    = A_INTC + int'(SLV_MAPSZ[SLV_INTCTRL]) / SEL_W;
	localparam int GA_DATA  = A_GPIOA + int'(GPIO_REG_DATA);
	localparam int GA_MASK  = A_GPIOA + int'(GPIO_REG_MASK);
	localparam int GB_DATA  = A_GPIOB + int'(GPIO_REG_DATA);
	localparam int GB_MASK  = A_GPIOB + int'(GPIO_REG_MASK);

	logic                   clk100mhz = 1'b0;
	logic                   rst_p;
	bus_op_t                op_i;
	logic [ADDR_W-1:0]      addr_i;
	logic [DATA_W-1:0]      data_i;
	logic [SEL_W-1:0]       sel_i;
	logic [DATA_W-1:0]      data_o;
	logic                   rdy_o;
	logic [GPIOA_COUNT-1:0] gpa_i;
	logic [GPIOA_COUNT-1:0] gpa_o;
	logic [GPIOB_COUNT-1:0] gpb_i;
	logic [GPIOB_COUNT-1:0] gpb_o;
	logic                   intrqst_o;

	int val_err = 0;
	int prot_err = 0;
	int cyc = 0;
	// enables the one-cycle answer check outside reset waits
	logic tchk = 1'b1;

	soc_top #(
		.GPIOA_COUNT (GPIOA_COUNT),
		.GPIOB_COUNT (GPIOB_COUNT),
		.RST_CYCLES  (RST_CYCLES)
	) i_dut (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.data_i    (data_i),
		.sel_i     (sel_i),
		.data_o    (data_o),
		.rdy_o     (rdy_o),
		.gpa_i     (gpa_i),
		.gpa_o     (gpa_o),
		.gpb_i     (gpb_i),
		.gpb_o     (gpb_o),
		.intrqst_o (intrqst_o)
	);

	always #5 clk100mhz = ~clk100mhz;

	always @(posedge clk100mhz) begin
		cyc = cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	a_rdy_latency: assert property (@(posedge clk100mhz) disable iff (rst_p || !tchk)
		$rose(op_i != OP_NOOP) |=> rdy_o)
		else begin
			prot_err++;
			$display("Error: t=%0t rdy_o expected 1 got 0 one cycle after op_i", $time);
		end

	a_rdy_pulse: assert property (@(posedge clk100mhz) disable iff (rst_p)
		rdy_o |=> !rdy_o)
		else begin
			prot_err++;
			$display("Error: t=%0t rdy_o expected 0 got 1 after a ready cycle", $time);
		end

	a_rdy_op: assert property (@(posedge clk100mhz) disable iff (rst_p)
		rdy_o |-> ($past(op_i) != OP_NOOP))
		else begin
			prot_err++;
			$display("rdy_o rose at t=%0t although no access was pending", $time);
		end

	function automatic logic [DATA_W-1:0] byte_mask(input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] m;
		m = '0;
		for (int b = 0; b < SEL_W; b++) begin
			m[8*b +: 8] = {8{sel[b]}};
		end
		return m;
	endfunction

	task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		assert (act === exp)
			else begin
				val_err++;
				$display("Error: t=%0t %s expected %h got %h", $time, name, exp, act);
			end
	endtask

	task automatic apply_reset();
		@(posedge clk100mhz);
		#1;
		rst_p = 1'b1;
		repeat (10) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		repeat (RST_CYCLES) @(posedge clk100mhz);
		#1;
	endtask

	// one bus access with the op held until rdy_o or max_wait cycles
	task automatic bus_xfer(input bus_op_t op, input int addr, input logic [DATA_W-1:0] wdata,
		input logic [SEL_W-1:0] sel, input int max_wait, output logic got,
		output logic [DATA_W-1:0] rdata, output int lat);
		@(posedge clk100mhz);
		#1;
		op_i   = op;
		addr_i = ADDR_W'(addr);
		data_i = wdata;
		sel_i  = sel;
		got    = 1'b0;
		rdata  = '0;
		lat    = 0;
		while (!got && lat < max_wait) begin
			@(posedge clk100mhz);
			#1;
			lat++;
			if (rdy_o) begin
				got   = 1'b1;
				rdata = data_o;
			end
		end
		op_i = OP_NOOP;
	endtask

	task automatic access(input bus_op_t op, input int addr, input logic [DATA_W-1:0] wdata,
		input logic [SEL_W-1:0] sel, output logic [DATA_W-1:0] rdata);
		logic got;
		int   lat;
		bus_xfer(op, addr, wdata, sel, NO_RDY_WAIT, got, rdata, lat);
		assert (got)
			else begin
				prot_err++;
				$display("no answer on the bus for word address %0d at t=%0t", addr, $time);
			end
	endtask

	task automatic write_word(input int addr, input logic [DATA_W-1:0] wdata,
		input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] unused;
		access(OP_WRITE, addr, wdata, sel, unused);
	endtask

	task automatic read_expect(input int addr, input string name,
		input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] rdata;
		access(OP_READ, addr, '0, '1, rdata);
		check_val(name, exp, rdata);
	endtask

	task automatic wait_intrqst(input logic level, input int limit);
		int n;
		n = 0;
		while (intrqst_o !== level && n < limit) begin
			@(posedge clk100mhz);
			#1;
			n++;
		end
		check_val("intrqst_o", DATA_W'(level), DATA_W'(intrqst_o));
	endtask

	initial begin
		logic [DATA_W-1:0]      d;
		logic [DATA_W-1:0]      m;
		logic [DATA_W-1:0]      exp;
		logic [DATA_W-1:0]      rdata;
		logic [SEL_W-1:0]       sel;
		logic [GPIOA_COUNT-1:0] exp_a;
		logic [GPIOB_COUNT-1:0] exp_b;
		logic                   got;
		int                     lat;

		void'($urandom(SEED));
		rst_p  = 1'b1;
		op_i   = OP_NOOP;
		addr_i = '0;
		data_i = '0;
		sel_i  = '0;
		gpa_i  = '0;
		gpb_i  = '0;
		apply_reset();
		check_val("rdy_o", '0, DATA_W'(rdy_o));
		check_val("intrqst_o", '0, DATA_W'(intrqst_o));
		check_val("gpa_o", '0, DATA_W'(gpa_o));
		check_val("gpb_o", '0, DATA_W'(gpb_o));

		// invalid device at byte address 112 and up
		read_expect(A_INV, "data_o", '0);
		read_expect(A_INV + 1, "data_o", '0);
		read_expect(A_INV + int'($urandom_range(0, 1000)), "data_o", '0);
		read_expect(32'h3fff_ffff, "data_o", '0);
		write_word(A_INV, 32'hdead_beef, '1);

		// device table
		read_expect(A_DEVTBL, "soc id", DATA_W'(SOC_ID));
		read_expect(A_DEVTBL + 1, "slave count", DATA_W'(SLV_COUNT));
		for (int k = 0; k < SLV_COUNT; k++) begin
			exp = (DATA_W'(SLV_USEINTR[k]) << 16) | DATA_W'(SLV_DEVID[k]);
			read_expect(A_DEVTBL + 2 + 2 * k, "device id", exp);
			read_expect(A_DEVTBL + 3 + 2 * k, "map size", DATA_W'(SLV_MAPSZ[k]));
		end
		for (int w = 2 + 2 * SLV_COUNT; w < A_GPIOA; w++) begin
			read_expect(A_DEVTBL + w, "unused table word", '0);
		end

		// gpio outputs with random byte enables
		exp_a = '0;
		exp_b = '0;
		for (int i = 0; i < 16; i++) begin
			d   = $urandom;
			sel = SEL_W'($urandom);
			m   = byte_mask(sel);
			write_word(GA_DATA, d, sel);
			exp_a = GPIOA_COUNT'((DATA_W'(exp_a) & ~m) | (d & m));
			check_val("gpa_o", DATA_W'(exp_a), DATA_W'(gpa_o));
			d   = $urandom;
			sel = SEL_W'($urandom);
			m   = byte_mask(sel);
			write_word(GB_DATA, d, sel);
			exp_b = GPIOB_COUNT'((DATA_W'(exp_b) & ~m) | (d & m));
			check_val("gpb_o", DATA_W'(exp_b), DATA_W'(gpb_o));
		end

		// gpio inputs held three cycles before the read
		for (int i = 0; i < 16; i++) begin
			@(posedge clk100mhz);
			#1;
			gpa_i = GPIOA_COUNT'($urandom);
			gpb_i = GPIOB_COUNT'($urandom);
			repeat (3) @(posedge clk100mhz);
			read_expect(GA_DATA, "gpio a input", DATA_W'(gpa_i));
			read_expect(GB_DATA, "gpio b input", DATA_W'(gpb_i));
		end

		// interrupts from both blocks are claimed lowest first
		write_word(GA_MASK, '1, '1);
		write_word(GB_MASK, '1, '1);
		read_expect(GA_MASK, "gpio a mask", DATA_W'({GPIOA_COUNT{1'b1}}));
		read_expect(GB_MASK, "gpio b mask", DATA_W'({GPIOB_COUNT{1'b1}}));
		check_val("intrqst_o", '0, DATA_W'(intrqst_o));
		@(posedge clk100mhz);
		#1;
		gpa_i = gpa_i ^ GPIOA_COUNT'(1);
		gpb_i = gpb_i ^ GPIOB_COUNT'(1);
		wait_intrqst(1'b1, 10);
		read_expect(A_INTC, "claim source 0", 32'h8000_0000 | DATA_W'(INT_SRC_GPIOA));
		read_expect(A_INTC, "claim source 1", 32'h8000_0000 | DATA_W'(INT_SRC_GPIOB));
		wait_intrqst(1'b0, 10);
		read_expect(A_INTC, "claim with none pending", '0);

		// masked-off change stays quiet
		write_word(GB_MASK, '0, '1);
		@(posedge clk100mhz);
		#1;
		gpb_i = ~gpb_i;
		repeat (8) begin
			@(posedge clk100mhz);
			#1;
			check_val("intrqst_o", '0, DATA_W'(intrqst_o));
		end

		// warm reset clears the outputs and holds the bus off for a while
		write_word(GA_DATA, 32'h0000_00a5, 4'h1);
		check_val("gpa_o", DATA_W'(GPIOA_COUNT'(8'ha5)), DATA_W'(gpa_o));
		write_word(GB_DATA, 32'h0000_0009, 4'h1);
		check_val("gpb_o", DATA_W'(GPIOB_COUNT'(4'h9)), DATA_W'(gpb_o));
		write_word(A_DEVTBL, 32'h2, '1);
		tchk = 1'b0;
		bus_xfer(OP_READ, A_DEVTBL, '0, '1, NO_RDY_WAIT, got, rdata, lat);
		assert (got && lat >= RST_CYCLES && lat <= RST_CYCLES + 2)
			else begin
				prot_err++;
				$display("Error: t=%0t rdy_o latency after warm reset expected %0d got %0d",
					$time, RST_CYCLES, lat);
			end
		tchk = 1'b1;
		check_val("soc id", DATA_W'(SOC_ID), rdata);
		check_val("gpa_o", '0, DATA_W'(gpa_o));
		check_val("gpb_o", '0, DATA_W'(gpb_o));

		// after power-off only a board reset brings the bus back
		write_word(A_DEVTBL, 32'h1, '1);
		tchk = 1'b0;
		bus_xfer(OP_READ, A_DEVTBL, '0, '1, NO_RDY_WAIT, got, rdata, lat);
		assert (!got)
			else begin
				prot_err++;
				$display("device table answered at t=%0t while powered off", $time);
			end
		bus_xfer(OP_READ, A_INV, '0, '1, NO_RDY_WAIT, got, rdata, lat);
		assert (!got)
			else begin
				prot_err++;
				$display("invalid device answered at t=%0t while powered off", $time);
			end
		apply_reset();
		tchk = 1'b1;
		read_expect(A_DEVTBL, "soc id", DATA_W'(SOC_ID));
		write_word(GA_DATA, 32'h0000_003c, 4'h1);
		check_val("gpa_o", DATA_W'(GPIOA_COUNT'(8'h3c)), DATA_W'(gpa_o));

		repeat (4) @(posedge clk100mhz);
		$display("errors: value %0d, protocol %0d", val_err, prot_err);
		if (val_err + prot_err == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/soc_top.sv ====
// ########################################################################
// soc top level
// peripheral side of the SoC: reset sequencer, bus router, device
// table, two gpio blocks and the interrupt controller
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int GPIOA_COUNT = 8,
	parameter int GPIOB_COUNT = 4,
	parameter int RST_CYCLES  = 16
) (
	input  logic                         clk100mhz,
	input  logic                         rst_p,
	input  soc_pkg::bus_op_t             op_i,
	input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
	input  logic [soc_pkg::DATA_W-1:0]   data_i,
	input  logic [soc_pkg::SEL_W-1:0]    sel_i,
	output logic [soc_pkg::DATA_W-1:0]   data_o,
	output logic                         rdy_o,
	input  logic [GPIOA_COUNT-1:0]       gpa_i,
	output logic [GPIOA_COUNT-1:0]       gpa_o,
	input  logic [GPIOB_COUNT-1:0]       gpb_i,
	output logic [GPIOB_COUNT-1:0]       gpb_o,
	output logic                         intrqst_o
);
	import soc_pkg::*;

	logic                     sys_rst;
	logic                     warm_req;
	logic                     off_req;
	bus_op_t                  s_op [SLV_COUNT];
	logic [DATA_W-1:0]        s_data [SLV_COUNT];
	logic [SLV_COUNT-1:0]     s_rdy;
	logic [INT_SRC_COUNT-1:0] int_req;
	logic [INT_SRC_COUNT-1:0] int_ack;

	reset_seq #(
		.RST_CYCLES (RST_CYCLES)
	) i_reset_seq (
		.clk100mhz  (clk100mhz),
		.rst_p      (rst_p),
		.warm_req_i (warm_req),
		.off_req_i  (off_req),
		.sys_rst_o  (sys_rst)
	);

	bus_router i_bus_router (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst),
		.op_i      (op_i),
		.addr_i    (addr_i),
		.data_o    (data_o),
		.rdy_o     (rdy_o),
		.s_op_o    (s_op),
		.s_data_i  (s_data),
		.s_rdy_i   (s_rdy)
	);

	dev_table i_dev_table (
		.clk100mhz  (clk100mhz),
		.sys_rst_i  (sys_rst),
		.op_i       (s_op[SLV_DEVTBL]),
		.addr_i     (addr_i),
		.data_i     (data_i),
		.data_o     (s_data[SLV_DEVTBL]),
		.rdy_o      (s_rdy[SLV_DEVTBL]),
		.warm_req_o (warm_req),
		.off_req_o  (off_req)
	);

	gpio #(
		.IO_COUNT (GPIOA_COUNT)
	) i_gpio_a (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst),
		.op_i      (s_op[SLV_GPIOA]),
		.addr_i    (addr_i),
		.data_i    (data_i),
		.sel_i     (sel_i),
		.data_o    (s_data[SLV_GPIOA]),
		.rdy_o     (s_rdy[SLV_GPIOA]),
		.io_i      (gpa_i),
		.io_o      (gpa_o),
		.int_req_o (int_req[INT_SRC_GPIOA]),
		.int_ack_i (int_ack[INT_SRC_GPIOA])
	);

	gpio #(
		.IO_COUNT (GPIOB_COUNT)
	) i_gpio_b (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst),
		.op_i      (s_op[SLV_GPIOB]),
		.addr_i    (addr_i),
		.data_i    (data_i),
		.sel_i     (sel_i),
		.data_o    (s_data[SLV_GPIOB]),
		.rdy_o     (s_rdy[SLV_GPIOB]),
		.io_i      (gpb_i),
		.io_o      (gpb_o),
		.int_req_o (int_req[INT_SRC_GPIOB]),
		.int_ack_i (int_ack[INT_SRC_GPIOB])
	);

	int_ctrl #(
		.SRC_COUNT (INT_SRC_COUNT)
	) i_int_ctrl (
		.clk100mhz (clk100mhz),
		.sys_rst_i (sys_rst),
		.op_i      (s_op[SLV_INTCTRL]),
		.data_o    (s_data[SLV_INTCTRL]),
		.rdy_o     (s_rdy[SLV_INTCTRL]),
		.src_req_i (int_req),
		.src_ack_o (int_ack),
		.intrqst_o (intrqst_o)
	);

endmodule

`default_nettype wire

// ==== hdl/int_ctrl.sv ====
// ########################################################################
// interrupt controller
// raises the processor interrupt while any source is pending and
// unclaimed; a read returns and claims the lowest such source
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module int_ctrl #(
	parameter int SRC_COUNT = 2
) (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  soc_pkg::bus_op_t            op_i,
	output logic [soc_pkg::DATA_W-1:0]  data_o,
	output logic                        rdy_o,
	input  logic [SRC_COUNT-1:0]        src_req_i,
	output logic [SRC_COUNT-1:0]        src_ack_o,
	output logic                        intrqst_o
);
	import soc_pkg::*;

	logic                 start;
	logic                 rd;
	logic [SRC_COUNT-1:0] open_req;
	logic [SRC_COUNT-1:0] pick;
	logic [DATA_W-1:0]    claim_val;

	assign start    = (op_i != OP_NOOP) && !rdy_o;
	assign rd       = start && (op_i == OP_READ);
	assign open_req = src_req_i & ~src_ack_o;

	// scan from the top so the lowest open source wins
	always_comb begin
		pick      = '0;
		claim_val = '0;
		for (int i = SRC_COUNT - 1; i >= 0; i--) begin
			if (open_req[i]) begin
				pick      = SRC_COUNT'(1) << i;
				claim_val = {1'b1, (DATA_W - 1)'(i)};
			end
		end
	end

	// ack is held until the source withdraws its request
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_o     <= 1'b0;
			src_ack_o <= '0;
			intrqst_o <= 1'b0;
		end else begin
			rdy_o     <= start;
			src_ack_o <= (src_ack_o & src_req_i) | (rd ? pick : '0);
			intrqst_o <= |open_req;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rd)
			data_o <= claim_val;
	end

	for (genvar i = 0; i < SRC_COUNT; i++) begin : g_chk
		a_ack_on_req: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
			$rose(src_ack_o[i]) |-> src_req_i[i])
			else $error("int_ctrl: ack %0d raised without request", i);
	end

endmodule

`default_nettype wire

// ==== hdl/gpio.sv ====
// ########################################################################
// gpio block
// synchronized inputs, byte-enabled output register and a change
// interrupt mask driving a four-phase request to the int controller
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module gpio #(
	parameter int IO_COUNT = 8
) (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  soc_pkg::bus_op_t            op_i,
	input  logic [soc_pkg::ADDR_W-1:0]  addr_i,
	input  logic [soc_pkg::DATA_W-1:0]  data_i,
	input  logic [soc_pkg::SEL_W-1:0]   sel_i,
	output logic [soc_pkg::DATA_W-1:0]  data_o,
	output logic                        rdy_o,
	input  logic [IO_COUNT-1:0]         io_i,
	output logic [IO_COUNT-1:0]         io_o,
	output logic                        int_req_o,
	input  logic                        int_ack_i
);
	import soc_pkg::*;

	logic [IO_COUNT-1:0] sync1_q;
	logic [IO_COUNT-1:0] sync2_q;
	logic [IO_COUNT-1:0] prev_q;
	logic [IO_COUNT-1:0] mask_q;
	logic [1:0]          reg_sel;
	logic                start;
	logic                wr;
	logic                chg;
	logic                again_q;

	assign start   = (op_i != OP_NOOP) && !rdy_o;
	assign wr      = start && (op_i == OP_WRITE);
	assign reg_sel = addr_i[1:0];
	assign chg     = |((sync2_q ^ prev_q) & mask_q);

	// two-flop synchronizer, prev_q keeps the last sample for change detect
	always_ff @(posedge clk100mhz) begin
		sync1_q <= io_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_o  <= 1'b0;
			io_o   <= '0;
			mask_q <= '0;
		end else begin
			rdy_o <= start;
			for (int i = 0; i < IO_COUNT; i++) begin
				if (wr && sel_i[i / 8]) begin
					if (reg_sel == GPIO_REG_DATA)
						io_o[i] <= data_i[i];
					if (reg_sel == GPIO_REG_MASK)
						mask_q[i] <= data_i[i];
				end
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (start) begin
			case (reg_sel)
				GPIO_REG_DATA: data_o <= DATA_W'(sync2_q);
				GPIO_REG_MASK: data_o <= DATA_W'(mask_q);
				default:       data_o <= '0;
			endcase
		end
	end

	// request drops on ack; a change seen meanwhile is kept in again_q
	// and raised once ack has gone low
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			int_req_o <= 1'b0;
			again_q   <= 1'b0;
		end else if (int_ack_i) begin
			int_req_o <= 1'b0;
			if (chg)
				again_q <= 1'b1;
		end else if (chg || again_q) begin
			int_req_o <= 1'b1;
			again_q   <= 1'b0;
		end
	end

	a_req_held: assert property (@(posedge clk100mhz)
		(int_req_o && !int_ack_i && !sys_rst_i) |=> int_req_o)
		else $error("gpio: int_req_o dropped before int_ack_i");

endmodule

`default_nettype wire

// ==== hdl/dev_table.sv ====
// ########################################################################
// device table
// read-only description of the SoC and of each slave in map order,
// plus the software reset register at word 0
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module dev_table (
	input  logic                        clk100mhz,
	input  logic                        sys_rst_i,
	input  soc_pkg::bus_op_t            op_i,
	input  logic [soc_pkg::ADDR_W-1:0]  addr_i,
	input  logic [soc_pkg::DATA_W-1:0]  data_i,
	output logic [soc_pkg::DATA_W-1:0]  data_o,
	output logic                        rdy_o,
	output logic                        warm_req_o,
	output logic                        off_req_o
);
	import soc_pkg::*;

	localparam int WORD_W = $clog2(SLV_MAPSZ[SLV_DEVTBL] / SEL_W);

	logic              start;
	logic              rst_wr;
	logic [WORD_W-1:0] word;
	logic [DATA_W-1:0] rd_val;

	assign start  = (op_i != OP_NOOP) && !rdy_o;
	assign word   = addr_i[WORD_W-1:0];
	assign rst_wr = start && (op_i == OP_WRITE) && (word == '0);

	// two words per slot: id with useintr flag, then map size
	always_comb begin
		rd_val = '0;
		if (word == WORD_W'(0))
			rd_val = DATA_W'(SOC_ID);
		if (word == WORD_W'(1))
			rd_val = DATA_W'(SLV_COUNT);
		for (int k = 0; k < SLV_COUNT; k++) begin
			if (word == WORD_W'(2 + 2 * k)) begin
				rd_val[15:0] = 16'(SLV_DEVID[k]);
				rd_val[16]   = SLV_USEINTR[k];
			end
			if (word == WORD_W'(3 + 2 * k))
				rd_val = DATA_W'(SLV_MAPSZ[k]);
		end
	end

	// 01 powers off, 10 and 11 both give a warm reset
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rdy_o      <= 1'b0;
			warm_req_o <= 1'b0;
			off_req_o  <= 1'b0;
		end else begin
			rdy_o      <= start;
			warm_req_o <= rst_wr && data_i[1];
			off_req_o  <= rst_wr && (data_i[1:0] == 2'b01);
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (start)
			data_o <= rd_val;
	end

endmodule

`default_nettype wire

// ==== hdl/bus_router.sv ====
// ########################################################################
// bus router
// decodes the word address to one slave, forwards the op there and
// returns that slave's data and ready; out-of-map accesses are answered
// by a built-in invalid device
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module bus_router (
	input  logic                          clk100mhz,
	input  logic                          sys_rst_i,
	input  soc_pkg::bus_op_t              op_i,
	input  logic [soc_pkg::ADDR_W-1:0]    addr_i,
	output logic [soc_pkg::DATA_W-1:0]    data_o,
	output logic                          rdy_o,
	output soc_pkg::bus_op_t              s_op_o [soc_pkg::SLV_COUNT],
	input  logic [soc_pkg::DATA_W-1:0]    s_data_i [soc_pkg::SLV_COUNT],
	input  logic [soc_pkg::SLV_COUNT-1:0] s_rdy_i
);
	import soc_pkg::*;

	// first word address past the last real slave
	function automatic int unsigned map_end_words();
		int unsigned sum;
		sum = 0;
		for (int k = 0; k < SLV_COUNT; k++) begin
			sum += SLV_MAPSZ[k] / SEL_W;
		end
		return sum;
	endfunction

	localparam int unsigned MAP_END = map_end_words();

	logic [SLV_COUNT-1:0] hit;
	logic                 inv_hit;
	logic                 inv_rdy_q;
	logic [SLV_COUNT:0]   rdy_all;

	// base of each slave is the running sum of the sizes before it
	always_comb begin
		logic [ADDR_W-1:0] base;
		base = '0;
		for (int k = 0; k < SLV_COUNT; k++) begin
			hit[k] = (addr_i >= base) && (addr_i < base + ADDR_W'(SLV_MAPSZ[k] / SEL_W));
			base = base + ADDR_W'(SLV_MAPSZ[k] / SEL_W);
		end
	end

	assign inv_hit = (addr_i >= ADDR_W'(MAP_END));

	for (genvar k = 0; k < SLV_COUNT; k++) begin : g_op
		assign s_op_o[k] = hit[k] ? op_i : OP_NOOP;
	end

	// invalid device reads as zero
	always_comb begin
		data_o = '0;
		for (int k = 0; k < SLV_COUNT; k++) begin
			if (hit[k])
				data_o = s_data_i[k];
		end
	end

	// invalid device answers one cycle after the op shows up
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			inv_rdy_q <= 1'b0;
		end else begin
			inv_rdy_q <= inv_hit && (op_i != OP_NOOP) && !inv_rdy_q;
		end
	end

	assign rdy_all = {inv_rdy_q, s_rdy_i};
	assign rdy_o   = |rdy_all;

	// decode must never let two slaves answer together
	a_one_rdy: assert property (@(posedge clk100mhz) disable iff (sys_rst_i)
		$onehot0(rdy_all))
		else $error("bus_router: more than one slave ready (%b)", rdy_all);

endmodule

`default_nettype wire

// ==== hdl/reset_seq.sv ====
// ########################################################################
// reset sequencer
// holds the system reset for a fixed count after board or warm reset,
// and keeps it asserted after a power-off request until board reset
// ########################################################################

`timescale 1ns/1ps
`default_nettype none

module reset_seq #(
	parameter int RST_CYCLES = 16
) (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic warm_req_i,
	input  logic off_req_i,
	output logic sys_rst_o
);
	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;
	logic             off_q;

	// reload on either reset source, then count down to release
	always_ff @(posedge clk100mhz) begin
		if (rst_p || warm_req_i) begin
			cnt_q <= CNT_W'(RST_CYCLES);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// power-off latch, only board reset brings the system back
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			off_q <= 1'b0;
		end else if (off_req_i) begin
			off_q <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p || off_q || (cnt_q != '0);

	a_off_holds: assert property (@(posedge clk100mhz)
		(off_q && !rst_p) |=> (off_q && sys_rst_o))
		else $error("reset_seq: system left reset while powered off");

endmodule

`default_nettype wire

// ==== hdl/soc_pkg.sv ====
// ########################################################################
// soc package
// bus op encoding, slave map, device table contents and register offsets
// shared by the peripheral side of the SoC
// ########################################################################

`default_nettype none

package soc_pkg;

	// bus operations, same codes as the processor side uses
	typedef enum logic [1:0] {
		OP_NOOP  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} bus_op_t;

	localparam int DATA_W = 32;
	// word address, byte address without its two low bits
	localparam int ADDR_W = 30;
	localparam int SEL_W  = 4;

	// slave indices, also the order of the address map
	localparam int SLV_DEVTBL  = 0;
	localparam int SLV_GPIOA   = 1;
	localparam int SLV_GPIOB   = 2;
	localparam int SLV_INTCTRL = 3;
	localparam int SLV_COUNT   = 4;

	// map size in bytes, slaves sit back to back from address 0
	localparam int unsigned SLV_MAPSZ [SLV_COUNT] = '{64, 16, 16, 16};
	localparam int unsigned SLV_DEVID [SLV_COUNT] = '{7, 6, 6, 3};
	localparam logic [SLV_COUNT-1:0] SLV_USEINTR = 4'b0110;

	localparam int unsigned SOC_ID = 3;

	// interrupt sources
	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_GPIOA = 0;
	localparam int INT_SRC_GPIOB = 1;

	// word offsets inside a gpio block
	localparam logic [1:0] GPIO_REG_DATA = 2'd0;
	localparam logic [1:0] GPIO_REG_MASK = 2'd1;

endpackage

`default_nettype wire
